// ==== aurora_lite.f ====
+incdir+.
aurora_lite_pkg.sv
aurora_lite_if.sv
tx_encoder.sv
tx_gearbox.sv
rx_gearbox.sv
block_sync.sv
rx_checker.sv
aurora_lite_top.sv
aurora_lite_tb.sv

// ==== aurora_lite_defines.svh ====
// link widths, ber marker and block sync limits, included by the rtl and the testbench
`ifndef AURORA_LITE_DEFINES_SVH
`define AURORA_LITE_DEFINES_SVH

// block with its 2-bit sync header
`define AL_BLOCK_W        66
`define AL_PAYLOAD_W      64
// line word per clk160 cycle
`define AL_LANE_W         32

// marker payload sent in ber mode
`define AL_BER_MARKER     64'hB0B5_C0CA_C01A_CAFE

// valid headers in a row needed for lock
// also the window length for invalid headers once locked
`define AL_SH_CNT_MAX     64
// invalid headers in one window that drop lock
`define AL_SH_INVALID_MAX 16
// valid blocks skipped after each slip
`define AL_SLIP_WAIT      8

`define AL_BER_CNT_W      32

`endif

// ==== aurora_lite_if.sv ====
// receive block bus between rx gearbox, block sync and rx checker, one instance per link
`timescale 1ns/1ps
`include "aurora_lite_defines.svh"

interface rx_block_if;

    // aligned block, header in the top two bits
    logic [`AL_BLOCK_W-1:0] block;
    // one-cycle strobe per new block
    logic                   block_valid;
    // drop one line bit in the gearbox
    logic                   slip;
    // header alignment found
    logic                   locked;

    // rx gearbox side
    modport gearbox (output block, output block_valid, input slip);

    // block sync side
    modport ctrl (input block, input block_valid, output slip, output locked);

    // checker only listens
    modport check (input block, input block_valid, input locked);

endinterface

// ==== aurora_lite_pkg.sv ====
// sync header codes and the scrambler step functions shared by tx encoder and rx checker
`include "aurora_lite_defines.svh"

package aurora_lite_pkg;

    // sync header codes, never scrambled
    localparam logic [1:0] hdr_data = 2'b01;
    localparam logic [1:0] hdr_ctrl = 2'b10;

    // polynomial 1 + x^39 + x^58
    localparam int scr_state_w = 58;

    // bit 63 leaves the link first so it is processed first
    // state bit 0 holds the newest scrambled bit
    function automatic void scramble_step(
        input  logic [`AL_PAYLOAD_W-1:0] din,
        input  logic [scr_state_w-1:0]   state_in,
        output logic [`AL_PAYLOAD_W-1:0] dout,
        output logic [scr_state_w-1:0]   state_out
    );
        logic [scr_state_w-1:0] s;
        s = state_in;
        for (int i = `AL_PAYLOAD_W - 1; i >= 0; i--) begin
            dout[i] = din[i] ^ s[38] ^ s[57];
            // feedback from the scrambled output
            s = {s[scr_state_w-2:0], dout[i]};
        end
        state_out = s;
    endfunction

    // self-synchronous inverse, state fed from the line bits
    function automatic void descramble_step(
        input  logic [`AL_PAYLOAD_W-1:0] din,
        input  logic [scr_state_w-1:0]   state_in,
        output logic [`AL_PAYLOAD_W-1:0] dout,
        output logic [scr_state_w-1:0]   state_out
    );
        logic [scr_state_w-1:0] s;
        s = state_in;
        for (int i = `AL_PAYLOAD_W - 1; i >= 0; i--) begin
            dout[i] = din[i] ^ s[38] ^ s[57];
            s = {s[scr_state_w-2:0], din[i]};
        end
        state_out = s;
    endfunction

endpackage

// ==== aurora_lite_tb.sv ====
// directed testbench for aurora_lite_top, loops tx_data back to rx_data through a bit shifter
`timescale 1ns/1ps
`include "aurora_lite_defines.svh"

module aurora_lite_tb;

    // whole run, about 66 slips of 140 cycles per lock hunt
    localparam int run_limit  = 20000;
    localparam int lock_limit = 66 * 140;
    // lock must go within four windows of blocks, plus pipeline slack
    localparam int drop_limit = 4 * `AL_SH_CNT_MAX * `AL_BLOCK_W / `AL_LANE_W + 20;
    localparam int word_limit = 200;

    logic                     clk160;
    logic                     rst;
    logic [1:0]               pattern_sel;
    logic [`AL_PAYLOAD_W-1:0] user_word;
    logic [`AL_LANE_W-1:0]    tx_data;
    logic [`AL_LANE_W-1:0]    rx_data;
    logic                     rx_locked;
    logic [`AL_PAYLOAD_W-1:0] rx_word;
    logic                     rx_word_valid;
    logic [`AL_BER_CNT_W-1:0] ber_cnt;

    // loopback line state
    logic [`AL_LANE_W-1:0]    lane_cur;
    logic [`AL_LANE_W-1:0]    line_next;
    logic [`AL_LANE_W-1:0]    flip_mask;
    logic                     line_down;
    int                       offset;
    int                       errors;
    int                       cycles;
    int unsigned              rnd;

    aurora_lite_top u_aurora_lite_top (
        .clk160        (clk160),
        .rst           (rst),
        .pattern_sel   (pattern_sel),
        .user_word     (user_word),
        .tx_data       (tx_data),
        .rx_data       (rx_data),
        .rx_locked     (rx_locked),
        .rx_word       (rx_word),
        .rx_word_valid (rx_word_valid),
        .ber_cnt       (ber_cnt)
    );

    initial clk160 = 1'b0;
    always #2 clk160 = ~clk160;

    // ========================================================================
    // loopback shifter, older lane on top
    // ========================================================================
    always @(posedge clk160) begin
        lane_cur  <= tx_data ^ flip_mask;
        flip_mask <= '0;
        if (line_down) begin
            line_next <= '0;
        end else begin
            line_next <= 32'({lane_cur, tx_data ^ flip_mask} >> offset);
        end
    end

    // line word reaches the DUT just after the edge
    always @(posedge clk160) begin
        #0.5;
        rx_data = line_next;
    end

    // run watchdog
    always @(posedge clk160) begin
        cycles = cycles + 1;
        if (cycles >= run_limit) begin
            $display("run stopped after %0d cycles without finishing the tests", cycles);
            $display("errors: %0d", errors);
            $display("TESTBENCH FAILED");
            $finish;
        end
    end

    task automatic step();
        @(posedge clk160);
        #0.5;
    endtask

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        if (got !== exp) begin
            $display("Mismatch %s: got 0x%h, expected 0x%h", name, got, exp);
            errors = errors + 1;
        end
    endtask

    task automatic wait_lock();
        int n;
        n = 0;
        while (!rx_locked && n < lock_limit) begin
            step();
            n = n + 1;
        end
        if (!rx_locked) begin
            $display("rx_locked did not rise within %0d cycles", lock_limit);
            errors = errors + 1;
        end
    endtask

    // next rx_word_valid, every cycle sampled once
    task automatic get_word(output logic [63:0] w);
        int n;
        n = 0;
        w = '0;
        do begin
            step();
            n = n + 1;
        end while (!rx_word_valid && n < word_limit);
        if (rx_word_valid) begin
            w = rx_word;
        end else begin
            $display("no rx_word_valid within %0d cycles", word_limit);
            errors = errors + 1;
        end
    endtask

    task automatic flip_bit(input int lane_bit);
        flip_mask = 32'd1 << lane_bit;
    endtask

    task automatic hold_locked(input int n);
        repeat (n) begin
            step();
            check_value("rx_locked", 64'(rx_locked), 64'd1);
        end
    endtask

    // ========================================================================
    // directed tests
    // ========================================================================
    task automatic test_reset_lock();
        check_value("rx_locked", 64'(rx_locked), 64'd0);
        check_value("rx_word_valid", 64'(rx_word_valid), 64'd0);
        check_value("ber_cnt", 64'(ber_cnt), 64'd0);
        wait_lock();
        hold_locked(200);
        // clean marker stream after lock
        check_value("ber_cnt", 64'(ber_cnt), 64'd0);
    endtask

    task automatic test_user_word();
        logic [63:0] w;
        pattern_sel = 2'd2;
        user_word   = {$urandom, $urandom};
        // first two words may still be in flight
        get_word(w);
        get_word(w);
        repeat (20) begin
            get_word(w);
            check_value("rx_word", w, user_word);
        end
    endtask

    task automatic test_counting();
        logic [63:0] w;
        logic [63:0] exp;
        int          n;
        pattern_sel = 2'd1;
        // user blocks still in the pipe come out first
        n = 0;
        get_word(w);
        while (w == user_word && n < 8) begin
            get_word(w);
            n = n + 1;
        end
        // counter held at zero outside counting mode
        exp = 64'd0;
        check_value("rx_word", w, exp);
        repeat (29) begin
            get_word(w);
            exp = exp + 64'd1;
            check_value("rx_word", w, exp);
        end
    endtask

    task automatic test_marker_errors();
        logic [`AL_BER_CNT_W-1:0] base;
        int                       rise;
        pattern_sel = 2'd0;
        repeat (40) step();
        base = ber_cnt;
        hold_locked(200);
        check_value("ber_cnt", 64'(ber_cnt), 64'(base));
        repeat (4) begin
            flip_bit(int'($urandom % 32));
            hold_locked(20);
        end
        hold_locked(40);
        // up to three descrambled errors per line error
        rise = int'(ber_cnt - base);
        if (rise < 1 || rise > 12) begin
            $display("ber_cnt rose by %0d after four bit flips, outside 1 to 12", rise);
            errors = errors + 1;
        end
    endtask

    task automatic test_relock();
        int n;
        line_down = 1'b1;
        n = 0;
        while (rx_locked && n < drop_limit) begin
            step();
            n = n + 1;
        end
        if (rx_locked) begin
            $display("rx_locked stayed high %0d cycles after the line went dead", drop_limit);
            errors = errors + 1;
        end
        offset    = int'($urandom % 32);
        line_down = 1'b0;
        wait_lock();
        test_user_word();
    endtask

    initial begin
        rnd         = $urandom(32'h90dcb74a);
        errors      = 0;
        cycles      = 0;
        rst         = 1'b1;
        pattern_sel = 2'd0;
        user_word   = '0;
        rx_data     = '0;
        lane_cur    = '0;
        line_next   = '0;
        flip_mask   = '0;
        line_down   = 1'b0;
        offset      = int'(rnd % 32);
        repeat (8) @(posedge clk160);
        #0.5;
        rst = 1'b0;

        test_reset_lock();
        test_user_word();
        test_counting();
        test_marker_errors();
        test_relock();

        $display("errors: %0d", errors);
        if (errors == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

// ==== aurora_lite_top.sv ====
// aurora lite link top, joins the tx path and the rx path on one clk160 domain
`timescale 1ns/1ps
`include "aurora_lite_defines.svh"

module aurora_lite_top (
    input  logic                     clk160,
    input  logic                     rst,
    input  logic [1:0]               pattern_sel,
    input  logic [`AL_PAYLOAD_W-1:0] user_word,
    output logic [`AL_LANE_W-1:0]    tx_data,
    input  logic [`AL_LANE_W-1:0]    rx_data,
    output logic                     rx_locked,
    output logic [`AL_PAYLOAD_W-1:0] rx_word,
    output logic                     rx_word_valid,
    output logic [`AL_BER_CNT_W-1:0] ber_cnt
);
    logic [`AL_BLOCK_W-1:0] tx_block;
    logic                   tx_block_next;

    rx_block_if rxb ();

    // ======================================================================
    // transmit
    // ======================================================================
    tx_encoder u_tx_encoder (
        .clk160      (clk160),
        .rst         (rst),
        .pattern_sel (pattern_sel),
        .user_word   (user_word),
        .block_next  (tx_block_next),
        .block       (tx_block)
    );

    tx_gearbox u_tx_gearbox (
        .clk160     (clk160),
        .rst        (rst),
        .block      (tx_block),
        .block_next (tx_block_next),
        .tx_data    (tx_data)
    );

    // ======================================================================
    // receive
    // ======================================================================
    rx_gearbox u_rx_gearbox (
        .clk160  (clk160),
        .rst     (rst),
        .rx_data (rx_data),
        .rxb     (rxb)
    );

    block_sync u_block_sync (
        .clk160 (clk160),
        .rst    (rst),
        .rxb    (rxb)
    );

    rx_checker u_rx_checker (
        .clk160        (clk160),
        .rst           (rst),
        .rxb           (rxb),
        .rx_word       (rx_word),
        .rx_word_valid (rx_word_valid),
        .ber_cnt       (ber_cnt)
    );

    assign rx_locked = rxb.locked;

endmodule

// ==== block_sync.sv ====
// rx block sync FSM, hunts for header alignment with slips and reports lock
`timescale 1ns/1ps
`include "aurora_lite_defines.svh"

module block_sync (
    input  logic clk160,
    input  logic rst,
    rx_block_if.ctrl rxb
);
    import aurora_lite_pkg::*;

    localparam int sh_w   = $clog2(`AL_SH_CNT_MAX);
    localparam int inv_w  = $clog2(`AL_SH_INVALID_MAX + 1);
    localparam int wait_w = $clog2(`AL_SLIP_WAIT + 1);

    logic [sh_w-1:0]   sh_cnt;
    logic [inv_w-1:0]  inv_cnt;
    logic [wait_w-1:0] wait_cnt;
    logic [1:0]        header;
    logic              hdr_ok;
    logic              window_end;
    logic              inv_limit;

    assign header     = rxb.block[`AL_BLOCK_W-1 -: 2];
    // 00 and 11 never appear on an aligned link
    assign hdr_ok     = (header == hdr_data) || (header == hdr_ctrl);
    assign window_end = (sh_cnt == sh_w'(`AL_SH_CNT_MAX - 1));
    assign inv_limit  = (inv_cnt == inv_w'(`AL_SH_INVALID_MAX - 1));

    // ======================================================================
    // two states, locked low is hunt
    // ======================================================================
    always_ff @(posedge clk160) begin
        if (rst) begin
            rxb.locked <= 1'b0;
            rxb.slip   <= 1'b0;
            sh_cnt     <= '0;
            inv_cnt    <= '0;
            wait_cnt   <= '0;
        end else begin
            rxb.slip <= 1'b0;
            if (rxb.block_valid) begin
                if (wait_cnt != '0) begin
                    // gearbox still settling after a slip
                    wait_cnt <= wait_cnt - 1'b1;
                end else if (!rxb.locked) begin
                    // hunt
                    if (!hdr_ok) begin
                        rxb.slip <= 1'b1;
                        sh_cnt   <= '0;
                        wait_cnt <= wait_w'(`AL_SLIP_WAIT);
                    end else if (window_end) begin
                        rxb.locked <= 1'b1;
                        sh_cnt     <= '0;
                        inv_cnt    <= '0;
                    end else begin
                        sh_cnt <= sh_cnt + 1'b1;
                    end
                end else begin
                    // locked, invalid headers tallied per window
                    if (!hdr_ok && inv_limit) begin
                        rxb.locked <= 1'b0;
                        rxb.slip   <= 1'b1;
                        sh_cnt     <= '0;
                        inv_cnt    <= '0;
                        wait_cnt   <= wait_w'(`AL_SLIP_WAIT);
                    end else if (window_end) begin
                        sh_cnt  <= '0;
                        inv_cnt <= '0;
                    end else begin
                        sh_cnt <= sh_cnt + 1'b1;
                        if (!hdr_ok) begin
                            inv_cnt <= inv_cnt + 1'b1;
                        end
                    end
                end
            end
        end
    end

    // gearbox drops exactly one bit per slip
    a_slip_pulse: assert property (@(posedge clk160) disable iff (rst)
        rxb.slip |=> !rxb.slip);

    a_slip_hunt: assert property (@(posedge clk160) disable iff (rst)
        !(rxb.slip && rxb.locked));

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# build the aurora_lite testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module aurora_lite_tb -f aurora_lite.f

out=$(./obj_dir/Vaurora_lite_tb)
echo "$out"

# the run passes only if the pass line was printed
echo "$out" | grep -qx "TESTBENCH PASSED"

// ==== rx_checker.sv ====
// rx checker, descrambles locked blocks, counts marker bit errors and outputs data words
`timescale 1ns/1ps
`include "aurora_lite_defines.svh"

module rx_checker (
    input  logic                     clk160,
    input  logic                     rst,
    rx_block_if.check                rxb,
    output logic [`AL_PAYLOAD_W-1:0] rx_word,
    output logic                     rx_word_valid,
    output logic [`AL_BER_CNT_W-1:0] ber_cnt
);
    import aurora_lite_pkg::*;

    logic [scr_state_w-1:0]   dsc_state;
    logic [scr_state_w-1:0]   dsc_state_nx;
    logic [`AL_PAYLOAD_W-1:0] dsc_word;
    logic [`AL_BER_CNT_W-1:0] err_bits;
    logic [1:0]               header;
    logic                     primed;
    logic                     take;

    assign header = rxb.block[`AL_BLOCK_W-1 -: 2];
    assign take   = rxb.block_valid && rxb.locked;

    always_comb begin
        descramble_step(rxb.block[`AL_PAYLOAD_W-1:0], dsc_state, dsc_word, dsc_state_nx);
    end

    // bits off the marker in this block
    assign err_bits = `AL_BER_CNT_W'($countones(dsc_word ^ `AL_BER_MARKER));

    always_ff @(posedge clk160) begin
        if (rst) begin
            dsc_state     <= '1;
            primed        <= 1'b0;
            rx_word_valid <= 1'b0;
            ber_cnt       <= '0;
        end else begin
            rx_word_valid <= 1'b0;
            if (!rxb.locked) begin
                // start over on the next lock
                dsc_state <= '1;
                primed    <= 1'b0;
            end else if (rxb.block_valid) begin
                dsc_state <= dsc_state_nx;
                // first block only fills the state
                primed    <= 1'b1;
                if (primed && header == hdr_data) begin
                    rx_word_valid <= 1'b1;
                end
                // ber_cnt keeps its sum across lock loss
                if (primed && header == hdr_ctrl) begin
                    ber_cnt <= ber_cnt + err_bits;
                end
            end
        end
    end

    always_ff @(posedge clk160) begin
        if (take && header == hdr_data) begin
            rx_word <= dsc_word;
        end
    end

    // words only come from blocks seen under lock
    a_word_locked: assert property (@(posedge clk160) disable iff (rst)
        rx_word_valid |-> $past(rxb.locked));

endmodule

// ==== rx_gearbox.sv ====
// rx 32-to-66 gearbox, collects lanes into blocks and drops one bit per slip pulse
`timescale 1ns/1ps
`include "aurora_lite_defines.svh"

module rx_gearbox (
    input  logic                  clk160,
    input  logic                  rst,
    input  logic [`AL_LANE_W-1:0] rx_data,
    rx_block_if.gearbox           rxb
);
    // 65 held bits plus one lane at most
    localparam int buf_w = `AL_BLOCK_W + `AL_LANE_W;

    logic [buf_w-1:0] acc_q;
    logic [buf_w-1:0] merged;
    logic [buf_w-1:0] aligned;
    logic [6:0]       cnt_q;
    logic [6:0]       total;
    logic [6:0]       avail;
    logic             full;

    // ======================================================================
    // bit accumulation
    // ======================================================================

    // lane bit 31 is the oldest, appended behind held bits
    always_comb begin
        merged = acc_q | ({rx_data, {`AL_BLOCK_W{1'b0}}} >> cnt_q);
        total  = cnt_q + 7'(`AL_LANE_W);
        if (rxb.slip) begin
            // oldest bit is thrown away
            aligned = merged << 1;
            avail   = total - 7'd1;
        end else begin
            aligned = merged;
            avail   = total;
        end
    end

    assign full = (avail >= 7'(`AL_BLOCK_W));

    always_ff @(posedge clk160) begin
        if (rst) begin
            acc_q           <= '0;
            cnt_q           <= '0;
            rxb.block_valid <= 1'b0;
        end else begin
            rxb.block_valid <= full;
            if (full) begin
                acc_q <= aligned << `AL_BLOCK_W;
                cnt_q <= avail - 7'(`AL_BLOCK_W);
            end else begin
                acc_q <= aligned;
                cnt_q <= avail;
            end
        end
    end

    // block out one cycle after its last bits
    always_ff @(posedge clk160) begin
        if (full) begin
            rxb.block <= aligned[buf_w-1 -: `AL_BLOCK_W];
        end
    end

endmodule

// ==== tx_encoder.sv ====
// tx pattern source and scrambler, builds one 66-bit block per gearbox request
`timescale 1ns/1ps
`include "aurora_lite_defines.svh"

module tx_encoder (
    input  logic                     clk160,
    input  logic                     rst,
    input  logic [1:0]               pattern_sel,
    input  logic [`AL_PAYLOAD_W-1:0] user_word,
    input  logic                     block_next,
    output logic [`AL_BLOCK_W-1:0]   block
);
    import aurora_lite_pkg::*;

    logic [`AL_PAYLOAD_W-1:0] count;
    logic [`AL_PAYLOAD_W-1:0] payload;
    logic [1:0]               header;
    logic [`AL_PAYLOAD_W-1:0] scr_word;
    logic [scr_state_w-1:0]   scr_state;
    logic [scr_state_w-1:0]   scr_state_nx;

    // payload and header per mode
    // 0 marker, 1 counting, 2 user word
    always_comb begin
        case (pattern_sel)
            2'd1: begin
                payload = count;
                header  = hdr_data;
            end
            2'd2: begin
                payload = user_word;
                header  = hdr_data;
            end
            default: begin
                payload = `AL_BER_MARKER;
                header  = hdr_ctrl;
            end
        endcase
    end

    // scramble payload only
    always_comb begin
        scramble_step(payload, scr_state, scr_word, scr_state_nx);
    end

    // scrambler state and counter move only on a request
    always_ff @(posedge clk160) begin
        if (rst) begin
            count     <= '0;
            scr_state <= '1;
        end else if (block_next) begin
            scr_state <= scr_state_nx;
            // counter stays put outside counting mode
            if (pattern_sel == 2'd1) begin
                count <= count + `AL_PAYLOAD_W'(1);
            end
        end
    end

    // new block visible the cycle after block_next
    always_ff @(posedge clk160) begin
        if (block_next) begin
            block <= {header, scr_word};
        end
    end

    // mode 3 is undefined and falls back to the marker
    a_sel_legal: assert property (@(posedge clk160) disable iff (rst)
        pattern_sel != 2'd3);

endmodule

// ==== tx_gearbox.sv ====
// tx 66-to-32 gearbox, shifts out one lane per cycle and requests blocks ahead of need
`timescale 1ns/1ps
`include "aurora_lite_defines.svh"

module tx_gearbox (
    input  logic                   clk160,
    input  logic                   rst,
    input  logic [`AL_BLOCK_W-1:0] block,
    output logic                   block_next,
    output logic [`AL_LANE_W-1:0]  tx_data
);
    // worst case 31 leftover bits plus one block
    localparam int buf_w = `AL_BLOCK_W + `AL_LANE_W;
    // 33 lanes carry exactly 16 blocks
    localparam int seq_n = 33;

    logic [buf_w-1:0] res_q;
    logic [buf_w-1:0] merged;
    logic [5:0]       seq;
    logic [5:0]       seq_ahead;
    logic [6:0]       cnt;
    logic             load;

    // residue bits at step s is (-32 * s) mod 66
    function automatic logic [6:0] res_bits(input logic [5:0] s);
        logic [11:0] prod;
        prod = 12'(s) * 12'(`AL_BLOCK_W - `AL_LANE_W);
        return 7'(prod % 12'(`AL_BLOCK_W));
    endfunction

    assign cnt  = res_bits(seq);
    // refill once less than a lane is left
    assign load = (cnt < 7'(`AL_LANE_W));

    // request is two steps ahead of the load
    // one cycle for this register and one for the encoder
    assign seq_ahead = (seq >= 6'(seq_n - 2)) ? seq - 6'(seq_n - 2) : seq + 6'd2;

    // oldest bit sits at the top, new block goes right behind the residue
    always_comb begin
        merged = res_q;
        if (load) begin
            merged = res_q | ({block, {`AL_LANE_W{1'b0}}} >> cnt);
        end
    end

    // reset at step 31 leaves 64 zero bits queued
    // so the first request lines up with the first load
    always_ff @(posedge clk160) begin
        if (rst) begin
            seq        <= 6'd31;
            res_q      <= '0;
            tx_data    <= '0;
            block_next <= 1'b0;
        end else begin
            seq        <= (seq == 6'(seq_n - 1)) ? 6'd0 : seq + 6'd1;
            tx_data    <= merged[buf_w-1 -: `AL_LANE_W];
            // zero fill keeps the unused tail clear
            res_q      <= merged << `AL_LANE_W;
            block_next <= (res_bits(seq_ahead) < 7'(`AL_LANE_W));
        end
    end

    // residue register holds nothing past its bit count
    a_res_fits: assert property (@(posedge clk160) disable iff (rst)
        (res_q << cnt) == '0);

    // every request is met by a load one cycle later
    a_req_load: assert property (@(posedge clk160) disable iff (rst)
        block_next |=> load);

endmodule
